// File: common/mipsCtrlPkg.sv
/*
 * Pipeline control definitions
 * Decoded control bundle, ALU operation codes and forwarding selects
 */
package mipsCtrlPkg;

   // Main decoder to ALU control
   typedef enum logic [1:0] {
      aluOpAdd,
      aluOpSub,
      aluOpFunct
   } aluOpT;

   // ALU function
   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluSlt,
      aluZero
   } aluCtrlT;

   // Operand source in execute
   typedef enum logic [1:0] {
      fwdReg,
      fwdMem,
      fwdWb
   } fwdSelT;

   // Control carried from decode down the pipeline
   typedef struct packed {
      logic  regWrite;
      logic  memToReg;
      logic  branch;
      logic  memRead;
      logic  memWrite;
      logic  regDst;
      logic  aluSrc;
      aluOpT aluOp;
   } ctrlT;

endpackage

// File: common/mipsIsaPkg.sv
/*
 * MIPS32 instruction set definitions
 * Word types, field positions, opcodes, funct codes and memory sizes
 */
package mipsIsaPkg;

   typedef logic [31:0] wordT;
   typedef logic [4:0]  regAddrT;
   typedef logic [5:0]  opcodeT;
   typedef logic [5:0]  functT;

   // Instruction field positions
   localparam int regAddrW = 5;
   localparam int rsLsb    = 21;
   localparam int rtLsb    = 16;
   localparam int rdLsb    = 11;
   localparam int immLsb   = 0;
   localparam int immW     = 16;
   localparam int opLsb    = 26;
   localparam int opW      = 6;
   localparam int fnLsb    = 0;
   localparam int fnW      = 6;

   // Supported opcodes
   localparam opcodeT opRType = 6'h00;
   localparam opcodeT opLw    = 6'h23;
   localparam opcodeT opSw    = 6'h2B;
   localparam opcodeT opBeq   = 6'h04;

   // R-type funct codes
   localparam functT fnAdd = 6'h20;
   localparam functT fnSub = 6'h22;
   localparam functT fnAnd = 6'h24;
   localparam functT fnOr  = 6'h25;
   localparam functT fnSlt = 6'h2A;

   // Memory depths in words, log2
   parameter int imemDepthLog2 = 6;
   parameter int dmemDepthLog2 = 6;

endpackage

// File: common/stageResultIf.sv
/*
 * Register write of a later pipeline stage
 * Seen by forwarding, the register file and the core outputs
 */
`timescale 1ns/1ps

interface stageResultIf;

   // Strobe is already qualified by a nonzero destination
   logic        regWrite;
   logic [4:0]  writeReg;
   logic [31:0] result;

   // Stage register producing the write
   modport source (output regWrite, writeReg, result);
   // Forwarding unit and operand muxes
   modport monitor (input regWrite, writeReg, result);
   // Register file write port
   modport write (input regWrite, writeReg, result);

endinterface

// File: decode/decodeStage.sv
/*
 * Decode stage
 * Main control, immediate sign extension and ID/EX register
 */
`timescale 1ns/1ps

module decodeStage
   import mipsIsaPkg::*, mipsCtrlPkg::*;
(
   input  logic    Clk,
   input  logic    arstN,
   input  wordT    instrId,
   input  wordT    pcPlus4Id,
   input  wordT    readData1,
   input  wordT    readData2,
   output regAddrT readAddr1,
   output regAddrT readAddr2,
   output ctrlT    ctrlEx,
   output wordT    pcPlus4Ex,
   output wordT    operand1Ex,
   output wordT    operand2Ex,
   output wordT    immEx,
   output regAddrT rsEx,
   output regAddrT rtEx,
   output regAddrT rdEx,
   output functT   functEx
);

   ctrlT ctrlId;
   wordT immId;

   // Register file reads use rs and rt directly
   assign readAddr1 = instrId[rsLsb +: regAddrW];
   assign readAddr2 = instrId[rtLsb +: regAddrW];
   assign immId = {{(32-immW){instrId[immLsb+immW-1]}}, instrId[immLsb +: immW]};

   // Main decoder, unknown opcodes stay inactive
   always_comb begin
      ctrlId = '0;
      case (instrId[opLsb +: opW])
         opRType: begin
            ctrlId.regWrite = 1'b1;
            ctrlId.regDst   = 1'b1;
            ctrlId.aluOp    = aluOpFunct;
         end
         opLw: begin
            ctrlId.regWrite = 1'b1;
            ctrlId.memToReg = 1'b1;
            ctrlId.memRead  = 1'b1;
            ctrlId.aluSrc   = 1'b1;
            ctrlId.aluOp    = aluOpAdd;
         end
         opSw: begin
            ctrlId.memWrite = 1'b1;
            ctrlId.aluSrc   = 1'b1;
            ctrlId.aluOp    = aluOpAdd;
         end
         opBeq: begin
            // Compare by subtraction
            ctrlId.branch = 1'b1;
            ctrlId.aluOp  = aluOpSub;
         end
         default: begin
            ctrlId = '0;
         end
      endcase
   end

   // ID/EX control
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         ctrlEx <= '0;
      end else begin
         ctrlEx <= ctrlId;
      end
   end

   // ID/EX payload
   always_ff @(posedge Clk) begin
      pcPlus4Ex  <= pcPlus4Id;
      operand1Ex <= readData1;
      operand2Ex <= readData2;
      immEx      <= immId;
      rsEx       <= instrId[rsLsb +: regAddrW];
      rtEx       <= instrId[rtLsb +: regAddrW];
      rdEx       <= instrId[rdLsb +: regAddrW];
      functEx    <= instrId[fnLsb +: fnW];
   end

endmodule

// File: decode/regFile.sv
/*
 * Register file
 * 32 words, write-through reads, r0 reads as zero
 */
`timescale 1ns/1ps

module regFile
   import mipsIsaPkg::*;
(
   input  logic               Clk,
   input  logic               arstN,
   input  regAddrT            readAddr1,
   input  regAddrT            readAddr2,
   stageResultIf.write        wbResult,
   output wordT               readData1,
   output wordT               readData2
);

   wordT regs [32];

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wbResult.regWrite && wbResult.writeReg != '0) begin
         regs[wbResult.writeReg] <= wbResult.result;
      end
   end

   // Same-cycle writeback bypasses the array
   assign readData1 = (readAddr1 == '0) ? '0 :
                      (wbResult.regWrite && wbResult.writeReg == readAddr1) ?
                      wbResult.result : regs[readAddr1];
   assign readData2 = (readAddr2 == '0) ? '0 :
                      (wbResult.regWrite && wbResult.writeReg == readAddr2) ?
                      wbResult.result : regs[readAddr2];

endmodule

// File: design/fetchStage.sv
/*
 * Fetch stage
 * PC, next-PC choice, loadable instruction memory and IF/ID register
 */
`timescale 1ns/1ps

module fetchStage
   import mipsIsaPkg::*;
#(
   parameter int imemDepthLog2 = mipsIsaPkg::imemDepthLog2
) (
   input  logic                     Clk,
   input  logic                     arstN,
   input  bit                       progWe,
   input  logic [imemDepthLog2-1:0] progAddr,
   input  wordT                     progData,
   input  bit                       pcSrc,
   input  wordT                     branchDest,
   output wordT                     instrId,
   output wordT                     pcPlus4Id
);

   wordT pc;
   wordT pcPlus4;
   wordT nextPc;
   wordT instrIf;
   wordT imem [2**imemDepthLog2];

   assign pcPlus4 = pc + 32'd4;
   // Taken beq from memory stage wins
   assign nextPc = pcSrc ? branchDest : pcPlus4;

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
      end else begin
         pc <= nextPc;
      end
   end

   // Program load, only while core held in reset
   always_ff @(posedge Clk) begin
      if (progWe && !arstN) begin
         imem[progAddr] <= progData;
      end
   end

   // Word addressed, async read
   assign instrIf = imem[pc[imemDepthLog2+1:2]];

   // IF/ID, instruction resets to nop
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         instrId <= '0;
      end else begin
         instrId <= instrIf;
      end
   end

   always_ff @(posedge Clk) begin
      pcPlus4Id <= pcPlus4;
   end

endmodule

// File: design/memoryStage.sv
/*
 * Memory stage
 * Data memory, branch decision, writeback select and MEM/WB register
 */
`timescale 1ns/1ps

module memoryStage
   import mipsIsaPkg::*, mipsCtrlPkg::*;
#(
   parameter int dmemDepthLog2 = mipsIsaPkg::dmemDepthLog2
) (
   input  logic                 Clk,
   input  logic                 arstN,
   input  ctrlT                 ctrlMem,
   input  wordT                 branchDestMem,
   input  wordT                 storeDataMem,
   input  bit                   zeroMem,
   stageResultIf.monitor        memResult,
   output bit                   pcSrc,
   output wordT                 branchDest,
   stageResultIf.source         wbResult
);

   wordT                     dmem [2**dmemDepthLog2];
   logic [dmemDepthLog2-1:0] dmemAddr;
   wordT                     loadData;
   wordT                     wbValue;

   // ALU result is the byte address, word aligned
   assign dmemAddr = memResult.result[dmemDepthLog2+1:2];
   assign loadData = ctrlMem.memRead ? dmem[dmemAddr] : '0;

   always_ff @(posedge Clk) begin
      if (ctrlMem.memWrite) begin
         dmem[dmemAddr] <= storeDataMem;
      end
   end

   // Branch resolved here, fetch redirected same cycle
   assign pcSrc      = ctrlMem.branch && zeroMem;
   assign branchDest = branchDestMem;

   assign wbValue = ctrlMem.memToReg ? loadData : memResult.result;

   // MEM/WB strobe
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         wbResult.regWrite <= 1'b0;
      end else begin
         wbResult.regWrite <= memResult.regWrite;
      end
   end

   // MEM/WB payload
   always_ff @(posedge Clk) begin
      wbResult.writeReg <= memResult.writeReg;
      wbResult.result   <= wbValue;
   end

endmodule

// File: design/mipsCore.sv
/*
 * Five-stage MIPS32 integer core
 * Program loaded during reset, observed at the register write port
 */
`timescale 1ns/1ps

module mipsCore
   import mipsIsaPkg::*, mipsCtrlPkg::*;
#(
   parameter int imemDepthLog2 = mipsIsaPkg::imemDepthLog2,
   parameter int dmemDepthLog2 = mipsIsaPkg::dmemDepthLog2
) (
   input  logic                     Clk,
   input  logic                     arstN,
   input  bit                       progWe,
   input  logic [imemDepthLog2-1:0] progAddr,
   input  wordT                     progData,
   output bit                       wbEn,
   output regAddrT                  wbReg,
   output wordT                     wbData
);

   wordT    instrId;
   wordT    pcPlus4Id;
   bit      pcSrc;
   wordT    branchDest;
   regAddrT readAddr1;
   regAddrT readAddr2;
   wordT    readData1;
   wordT    readData2;
   ctrlT    ctrlEx;
   wordT    pcPlus4Ex;
   wordT    operand1Ex;
   wordT    operand2Ex;
   wordT    immEx;
   regAddrT rsEx;
   regAddrT rtEx;
   regAddrT rdEx;
   functT   functEx;
   fwdSelT  fwdA;
   fwdSelT  fwdB;
   ctrlT    ctrlMem;
   wordT    branchDestMem;
   wordT    storeDataMem;
   bit      zeroMem;

   // EX/MEM and MEM/WB register writes
   stageResultIf memResult ();
   stageResultIf wbResult ();

   fetchStage #(.imemDepthLog2(imemDepthLog2)) fetchStage_i (
      .Clk, .arstN, .progWe, .progAddr, .progData,
      .pcSrc, .branchDest, .instrId, .pcPlus4Id
   );

   decodeStage decodeStage_i (
      .Clk, .arstN, .instrId, .pcPlus4Id, .readData1, .readData2,
      .readAddr1, .readAddr2, .ctrlEx, .pcPlus4Ex, .operand1Ex, .operand2Ex,
      .immEx, .rsEx, .rtEx, .rdEx, .functEx
   );

   regFile regFile_i (
      .Clk, .arstN, .readAddr1, .readAddr2, .wbResult, .readData1, .readData2
   );

   forwardUnit forwardUnit_i (
      .rsEx, .rtEx, .memResult, .wbResult, .fwdA, .fwdB
   );

   executeStage executeStage_i (
      .Clk, .arstN, .ctrlEx, .pcPlus4Ex, .operand1Ex, .operand2Ex, .immEx,
      .rtEx, .rdEx, .functEx, .fwdA, .fwdB, .memResult, .wbResult,
      .ctrlMem, .branchDestMem, .storeDataMem, .zeroMem
   );

   memoryStage #(.dmemDepthLog2(dmemDepthLog2)) memoryStage_i (
      .Clk, .arstN, .ctrlMem, .branchDestMem, .storeDataMem, .zeroMem,
      .memResult, .pcSrc, .branchDest, .wbResult
   );

   // Observation port follows MEM/WB
   assign wbEn   = wbResult.regWrite;
   assign wbReg  = wbResult.writeReg;
   assign wbData = wbResult.result;

endmodule

// File: execute/executeStage.sv
/*
 * Execute stage
 * Forwarded operands, ALU control and ALU, branch target, EX/MEM register
 */
`timescale 1ns/1ps

module executeStage
   import mipsIsaPkg::*, mipsCtrlPkg::*;
(
   input  logic                 Clk,
   input  logic                 arstN,
   input  ctrlT                 ctrlEx,
   input  wordT                 pcPlus4Ex,
   input  wordT                 operand1Ex,
   input  wordT                 operand2Ex,
   input  wordT                 immEx,
   input  regAddrT              rtEx,
   input  regAddrT              rdEx,
   input  functT                functEx,
   input  fwdSelT               fwdA,
   input  fwdSelT               fwdB,
   stageResultIf.source         memResult,
   stageResultIf.monitor        wbResult,
   output ctrlT                 ctrlMem,
   output wordT                 branchDestMem,
   output wordT                 storeDataMem,
   output bit                   zeroMem
);

   wordT    aluA;
   wordT    fwdOperandB;
   wordT    aluB;
   wordT    aluResult;
   wordT    branchDestEx;
   aluCtrlT aluCtrl;
   regAddrT destReg;
   ctrlT    ctrlNext;
   bit      zeroEx;

   function automatic wordT pickOperand(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
      case (sel)
         fwdMem:  return memVal;
         fwdWb:   return wbVal;
         default: return regVal;
      endcase
   endfunction

   assign aluA        = pickOperand(fwdA, operand1Ex, memResult.result, wbResult.result);
   assign fwdOperandB = pickOperand(fwdB, operand2Ex, memResult.result, wbResult.result);
   // Immediate for lw and sw address
   assign aluB = ctrlEx.aluSrc ? immEx : fwdOperandB;

   // ALU control, unsupported funct gives zero
   always_comb begin
      case (ctrlEx.aluOp)
         aluOpAdd: aluCtrl = aluAdd;
         aluOpSub: aluCtrl = aluSub;
         aluOpFunct: begin
            case (functEx)
               fnAdd:   aluCtrl = aluAdd;
               fnSub:   aluCtrl = aluSub;
               fnAnd:   aluCtrl = aluAnd;
               fnOr:    aluCtrl = aluOr;
               fnSlt:   aluCtrl = aluSlt;
               default: aluCtrl = aluZero;
            endcase
         end
         default: aluCtrl = aluZero;
      endcase
   end

   always_comb begin
      case (aluCtrl)
         aluAdd:  aluResult = aluA + aluB;
         aluSub:  aluResult = aluA - aluB;
         aluAnd:  aluResult = aluA & aluB;
         aluOr:   aluResult = aluA | aluB;
         aluSlt:  aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
         default: aluResult = '0;
      endcase
   end

   assign zeroEx       = (aluResult == '0);
   assign branchDestEx = pcPlus4Ex + {immEx[29:0], 2'b00};
   assign destReg      = ctrlEx.regDst ? rdEx : rtEx;

   // Writes to r0 dropped here, so forwarding never sees them
   always_comb begin
      ctrlNext          = ctrlEx;
      ctrlNext.regWrite = ctrlEx.regWrite && (destReg != '0);
   end

   // EX/MEM control
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         ctrlMem <= '0;
      end else begin
         ctrlMem <= ctrlNext;
      end
   end

   // EX/MEM payload
   always_ff @(posedge Clk) begin
      branchDestMem      <= branchDestEx;
      storeDataMem       <= fwdOperandB;
      zeroMem            <= zeroEx;
      memResult.writeReg <= destReg;
      memResult.result   <= aluResult;
   end

   assign memResult.regWrite = ctrlMem.regWrite;

endmodule

// File: execute/forwardUnit.sv
/*
 * Forwarding unit
 * Picks ALU operand sources from memory and writeback stage writes
 */
`timescale 1ns/1ps

module forwardUnit
   import mipsIsaPkg::*, mipsCtrlPkg::*;
(
   input  regAddrT              rsEx,
   input  regAddrT              rtEx,
   stageResultIf.monitor        memResult,
   stageResultIf.monitor        wbResult,
   output fwdSelT               fwdA,
   output fwdSelT               fwdB
);

   // Younger result in memory stage has priority
   function automatic fwdSelT pickSource(regAddrT srcReg, logic memWe, regAddrT memReg,
                                         logic wbWe, regAddrT wbReg);
      if (memWe && memReg == srcReg) begin
         return fwdMem;
      end else if (wbWe && wbReg == srcReg) begin
         return fwdWb;
      end
      return fwdReg;
   endfunction

   // r0 writes already suppressed upstream
   assign fwdA = pickSource(rsEx, memResult.regWrite, memResult.writeReg,
                            wbResult.regWrite, wbResult.writeReg);
   assign fwdB = pickSource(rtEx, memResult.regWrite, memResult.writeReg,
                            wbResult.regWrite, wbResult.writeReg);

endmodule

// File: mipsCore.f
common/mipsIsaPkg.sv
common/mipsCtrlPkg.sv
common/stageResultIf.sv
design/fetchStage.sv
decode/decodeStage.sv
decode/regFile.sv
execute/forwardUnit.sv
execute/executeStage.sv
design/memoryStage.sv
design/mipsCore.sv
tb/mipsCore_properties.sv
tb/mipsCoreTb.sv

// File: runSim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mipsCoreTb -f mipsCore.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: tb/mipsCoreTb.sv
/*
 * Testbench for the five-stage MIPS32 core
 * Loads each program from a table, checks writebacks in order
 */
`timescale 1ns/1ps

module mipsCoreTb
   import mipsIsaPkg::*;
;

   localparam int addrW    = 6;
   localparam int numTests = 5;
   localparam int maxProg  = 32;
   localparam int maxExp   = 16;
   localparam int drainCyc = 8;

   logic              Clk;
   logic              arstN;
   bit                progWe;
   logic [addrW-1:0]  progAddr;
   wordT              progData;
   bit                wbEn;
   regAddrT           wbReg;
   wordT              wbData;

   // Test table
   string   testName [numTests];
   int      progLen  [numTests];
   wordT    prog     [numTests][maxProg];
   int      expLen   [numTests];
   regAddrT expReg   [numTests][maxExp];
   wordT    expVal   [numTests][maxExp];

   int errors;
   int testErrors;
   int failedTests;
   int cycles;
   int cycleLimit;

   mipsCore #(.imemDepthLog2(addrW), .dmemDepthLog2(6)) mipsCore_i (
      .Clk, .arstN, .progWe, .progAddr, .progData, .wbEn, .wbReg, .wbData
   );

   initial begin
      Clk = 1'b0;
      forever #20 Clk = ~Clk;
   end

   // Cycle counter ends a stuck run
   initial begin
      cycles = 0;
      while (cycleLimit == 0 || cycles <= cycleLimit) begin
         @(posedge Clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, writebacks stopped arriving", cycles);
      $display("Finished with errors");
      $finish;
   end

   // Data memory seed, odd words negative
   function automatic wordT fillWord(int a);
      return (a[0] ? 32'hF000_0000 : 32'h0) | (32'(a) * 32'h0001_0203 + 32'h11);
   endfunction

   function automatic wordT rType(regAddrT rd, regAddrT rs, regAddrT rt, functT fn);
      return {opRType, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic wordT iType(opcodeT op, regAddrT rt, regAddrT rs, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic int loadLength(int t);
      return (progLen[t] + drainCyc + 2 > 64) ? 64 : progLen[t] + drainCyc + 2;
   endfunction

   function automatic int resetLength(int t);
      return (loadLength(t) > 8) ? loadLength(t) : 8;
   endfunction

   task automatic addInstr(int t, wordT w);
      prog[t][progLen[t]] = w;
      progLen[t]++;
   endtask

   task automatic addExpect(int t, regAddrT r, wordT v);
      expReg[t][expLen[t]] = r;
      expVal[t][expLen[t]] = v;
      expLen[t]++;
   endtask

   task automatic checkValue(string sigName, wordT got, wordT exp);
      if (got !== exp) begin
         $display("FAILED t=%0t %s got %h expected %h", $time, sigName, got, exp);
         testErrors++;
      end
   endtask

   task automatic buildTable();
      wordT f1;
      wordT f2;
      wordT f3;
      wordT f4;
      wordT r3;
      wordT r4;
      wordT r5;
      for (int t = 0; t < numTests; t++) begin
         progLen[t] = 0;
         expLen[t]  = 0;
      end
      // ALU operations, r1 negative
      f1 = fillWord(1);
      f2 = fillWord(2);
      testName[0] = "aluOps";
      addInstr(0, iType(opLw, 5'd1, 5'd0, 16'd4));
      addInstr(0, iType(opLw, 5'd2, 5'd0, 16'd8));
      addInstr(0, 32'h0);
      addInstr(0, rType(5'd3, 5'd1, 5'd2, fnAdd));
      addInstr(0, rType(5'd4, 5'd1, 5'd2, fnSub));
      addInstr(0, rType(5'd5, 5'd1, 5'd2, fnAnd));
      addInstr(0, rType(5'd6, 5'd1, 5'd2, fnOr));
      addInstr(0, rType(5'd7, 5'd1, 5'd2, fnSlt));
      addInstr(0, rType(5'd8, 5'd2, 5'd1, fnSlt));
      addExpect(0, 5'd1, f1);
      addExpect(0, 5'd2, f2);
      addExpect(0, 5'd3, f1 + f2);
      addExpect(0, 5'd4, f1 - f2);
      addExpect(0, 5'd5, f1 & f2);
      addExpect(0, 5'd6, f1 | f2);
      // Odd word negative, even word positive
      addExpect(0, 5'd7, 32'd1);
      addExpect(0, 5'd8, 32'd0);
      // Dependencies at distance 1, 2 and 3
      f3 = fillWord(3);
      f4 = fillWord(4);
      r3 = f3 + f4;
      r4 = r3 - f3;
      r5 = r3 | r4;
      testName[1] = "forwarding";
      addInstr(1, iType(opLw, 5'd1, 5'd0, 16'd12));
      addInstr(1, iType(opLw, 5'd2, 5'd0, 16'd16));
      addInstr(1, 32'h0);
      addInstr(1, rType(5'd3, 5'd1, 5'd2, fnAdd));
      addInstr(1, rType(5'd4, 5'd3, 5'd1, fnSub));
      addInstr(1, rType(5'd5, 5'd3, 5'd4, fnOr));
      addInstr(1, rType(5'd6, 5'd3, 5'd5, fnAnd));
      addExpect(1, 5'd1, f3);
      addExpect(1, 5'd2, f4);
      addExpect(1, 5'd3, r3);
      addExpect(1, 5'd4, r4);
      addExpect(1, 5'd5, r5);
      addExpect(1, 5'd6, r3 & r5);
      // Store then load back from word 25
      testName[2] = "memRoundTrip";
      addInstr(2, iType(opLw, 5'd1, 5'd0, 16'd20));
      addInstr(2, 32'h0);
      addInstr(2, iType(opSw, 5'd1, 5'd0, 16'd100));
      addInstr(2, 32'h0);
      addInstr(2, iType(opLw, 5'd2, 5'd0, 16'd100));
      addInstr(2, 32'h0);
      addInstr(2, rType(5'd3, 5'd2, 5'd0, fnAdd));
      addExpect(2, 5'd1, fillWord(5));
      addExpect(2, 5'd2, fillWord(5));
      addExpect(2, 5'd3, fillWord(5));
      // Taken beq skips two adds, then a not-taken beq
      testName[3] = "branches";
      addInstr(3, iType(opLw, 5'd1, 5'd0, 16'd24));
      addInstr(3, 32'h0);
      addInstr(3, iType(opBeq, 5'd1, 5'd1, 16'd5));
      addInstr(3, 32'h0);
      addInstr(3, 32'h0);
      addInstr(3, 32'h0);
      addInstr(3, rType(5'd2, 5'd1, 5'd1, fnAdd));
      addInstr(3, rType(5'd3, 5'd1, 5'd1, fnAdd));
      addInstr(3, rType(5'd4, 5'd1, 5'd0, fnOr));
      addInstr(3, iType(opBeq, 5'd0, 5'd1, 16'd3));
      addInstr(3, rType(5'd5, 5'd1, 5'd1, fnAdd));
      addInstr(3, 32'h0);
      addInstr(3, 32'h0);
      addInstr(3, rType(5'd6, 5'd1, 5'd1, fnAnd));
      addExpect(3, 5'd1, fillWord(6));
      addExpect(3, 5'd4, fillWord(6));
      addExpect(3, 5'd5, fillWord(6) + fillWord(6));
      addExpect(3, 5'd6, fillWord(6));
      // r0 write is dropped
      testName[4] = "regZero";
      addInstr(4, iType(opLw, 5'd1, 5'd0, 16'd28));
      addInstr(4, 32'h0);
      addInstr(4, rType(5'd0, 5'd1, 5'd1, fnAdd));
      addInstr(4, rType(5'd2, 5'd0, 5'd1, fnOr));
      addInstr(4, rType(5'd3, 5'd0, 5'd0, fnAdd));
      addExpect(4, 5'd1, fillWord(7));
      addExpect(4, 5'd2, fillWord(7));
      addExpect(4, 5'd3, 32'h0);
   endtask

   task automatic runTest(int t);
      int idx;
      @(negedge Clk);
      arstN = 1'b0;
      for (int i = 0; i < 64; i++) begin
         mipsCore_i.memoryStage_i.dmem[i] = fillWord(i);
      end
      // Program then trailing nops, written while in reset
      for (int c = 0; c < resetLength(t); c++) begin
         @(negedge Clk);
         progWe   = (c < loadLength(t));
         progAddr = addrW'(c);
         progData = (c < progLen[t]) ? prog[t][c] : 32'h0;
      end
      @(negedge Clk);
      progWe = 1'b0;
      arstN  = 1'b1;
      idx = 0;
      for (int c = 0; c < progLen[t] + drainCyc; c++) begin
         @(negedge Clk);
         if (wbEn) begin
            if (idx < expLen[t]) begin
               checkValue("wbReg", 32'(wbReg), 32'(expReg[t][idx]));
               checkValue("wbData", wbData, expVal[t][idx]);
               idx++;
            end else begin
               $display("Unexpected extra writeback to r%0d at %0t", wbReg, $time);
               testErrors++;
            end
         end
      end
      if (idx < expLen[t]) begin
         $display("Missing %0d writebacks in test %s", expLen[t] - idx, testName[t]);
         testErrors++;
      end
   endtask

   initial begin
      arstN       = 1'b0;
      progWe      = 1'b0;
      progAddr    = '0;
      progData    = '0;
      errors      = 0;
      failedTests = 0;
      cycleLimit  = 0;
      buildTable();
      // Program lengths plus 12 per test, plus reset and load
      for (int t = 0; t < numTests; t++) begin
         cycleLimit += progLen[t] + 12 + resetLength(t);
      end
      for (int t = 0; t < numTests; t++) begin
         testErrors = 0;
         runTest(t);
         $display("Test %s %s (%0d errors)", testName[t],
                  (testErrors == 0) ? "ok" : "BAD", testErrors);
         errors += testErrors;
         if (testErrors != 0) begin
            failedTests++;
         end
      end
      $display("Tests %0d, failed %0d, total errors %0d", numTests, failedTests, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: tb/mipsCore_properties.sv
/*
 * Writeback port properties, bound to the core
 */
`timescale 1ns/1ps

module mipsCore_properties
   import mipsIsaPkg::*;
(
   input logic    Clk,
   input logic    arstN,
   input bit      wbEn,
   input regAddrT wbReg,
   input logic    wbRegWrite
);

   // No writeback while held in reset
   wbQuietInReset: assert property (@(posedge Clk) !arstN |-> !wbEn)
      else $error("wbEn high during reset");

   // r0 writes never reach the port
   wbNotZeroReg: assert property (@(posedge Clk) disable iff (!arstN) wbEn |-> wbReg != '0)
      else $error("writeback to r0");

   // MEM/WB strobe as seen before the 2-state port
   wbEnKnown: assert property (@(posedge Clk) !$isunknown(wbRegWrite))
      else $error("wbEn unknown");

endmodule

bind mipsCore mipsCore_properties mipsCore_properties_i (
   .Clk(Clk), .arstN(arstN), .wbEn(wbEn), .wbReg(wbReg),
   .wbRegWrite(wbResult.regWrite)
);
